// File: hdl/bubbleDrive.sv
`timescale 1ns/10ps
`default_nettype none

module bubbleDrive import bubblePkg::*;
(
    input  wire          clock12MHz,
    input  wire          rstN,

    // Bubble controller levels
    input  wire          moduleEn,
    input  wire          shiftEnN,
    input  wire          repEnN,
    input  wire          bootEn,

    // Host store load
    input  wire          loadEn,
    input  storeAddr_u   loadAddr,
    input  bubbleWord_t  loadData,

    output wire          coilEnN,
    output wire          positionChange,
    output wire          positionLatch,
    output wire          pageSelect,
    output wire          dataOut,
    output wire          dataValid
);

    wire          replicate;
    wire          winA;
    wire          winB;
    storeAddr_u   rdAddr;
    bubbleWord_t  rdData;

    // Field timing and strobes
    timingGenerator uTiming
    (
        .clock12MHz     (clock12MHz),
        .rstN           (rstN),
        .moduleEn       (moduleEn),
        .shiftEnN       (shiftEnN),
        .repEnN         (repEnN),
        .bootEn         (bootEn),
        .coilEnN        (coilEnN),
        .positionChange (positionChange),
        .positionLatch  (positionLatch),
        .pageSelect     (pageSelect),
        .replicate      (replicate),
        .winA           (winA),
        .winB           (winB)
    );

    positionTracker uTracker
    (
        .clock12MHz     (clock12MHz),
        .rstN           (rstN),
        .positionChange (positionChange),
        .pageSelect     (pageSelect),
        .rdAddr         (rdAddr)
    );

    pageStore uStore
    (
        .clock12MHz     (clock12MHz),
        .loadEn         (loadEn),
        .loadAddr       (loadAddr),
        .loadData       (loadData),
        .rdAddr         (rdAddr),
        .replicate      (replicate),
        .rdData         (rdData)
    );

    // Serializer into the two windows
    bubbleOutput uOutput
    (
        .clock12MHz     (clock12MHz),
        .rstN           (rstN),
        .replicate      (replicate),
        .rdData         (rdData),
        .winA           (winA),
        .winB           (winB),
        .dataOut        (dataOut),
        .dataValid      (dataValid)
    );

endmodule

`default_nettype wire

// File: hdl/bubbleDrive_params.svh
`ifndef BUBBLEDRIVE_PARAMS_SVH
`define BUBBLEDRIVE_PARAMS_SVH

// Minor loop geometry
`define BUBBLE_POSITIONS 64     // Positions per loop revolution, power of two
`define POS_BITS         6      // log2 of BUBBLE_POSITIONS
`define DATA_BITS        2      // One bit per output window

// Control level synchronizer
`define SYNC_STAGES      3

// Rotation counter width
`define CNT_BITS         8

// Coil window, inclusive
`define CNT_COIL_ON      18
`define CNT_COIL_OFF     168

// Shifting loop, 120 clocks per rotation
`define CNT_LOOP         20     // Reload value after wrap
`define CNT_WRAP         139    // Last count of a rotation

// Stop sequence jump from -X straight into -Y
`define CNT_XEND         45
`define CNT_YSTART       166

// Position change pair starts here, lasts two counts
`define CNT_PCHG         138

// Replicate window
`define CNT_REP          21
`define REP_LEN          3

// Data output windows
`define CNT_WINA         24
`define CNT_WINB         84
`define WIN_LEN          10

`endif

// File: hdl/bubbleOutput.sv
`timescale 1ns/10ps
`default_nettype none

module bubbleOutput import bubblePkg::*;
(
    input  wire          clock12MHz,
    input  wire          rstN,

    input  wire          replicate,   // Replicate window
    input  bubbleWord_t  rdData,      // Word from the store
    input  wire          winA,        // Output window A
    input  wire          winB,        // Output window B

    output logic         dataOut,     // Serial bubble data
    output logic         dataValid    // High during a window of a replicated rotation
);

    bubbleWord_t  heldWord;           // Word captured for this rotation
    logic         repSeen;            // This rotation replicated
    logic         winBPrev;           // winB one clock back
    logic         winBEnd;
    logic         inWindow;

    assign winBEnd  = winBPrev & ~winB;
    assign inWindow = winA | winB;

    // Captured on every replicate clock so the last one sticks;
    // store read is valid from the second clock of the window
    always_ff @(posedge clock12MHz)
    begin
        if (replicate)
        begin
            heldWord <= rdData;
        end
    end

    always_ff @(posedge clock12MHz or negedge rstN)
    begin
        if (!rstN)
        begin
            repSeen  <= 1'b0;
            winBPrev <= 1'b0;
        end
        else
        begin
            winBPrev <= winB;
            if (replicate)
            begin
                repSeen <= 1'b1;              // Arm both windows
            end
            else if (winBEnd)
            begin
                repSeen <= 1'b0;              // Rotation's data fully sent
            end
        end
    end

    assign dataValid = repSeen & inWindow;
    assign dataOut   = dataValid & (winA ? heldWord[0] : heldWord[1]);

    // Windows sit 60 counts apart
    windowsDisjoint: assert property (@(posedge clock12MHz) disable iff (!rstN)
        !(winA && winB));

endmodule

`default_nettype wire

// File: hdl/bubblePkg.sv
`default_nettype none

package bubblePkg;

    `include "bubbleDrive_params.svh"

    // Store address, seen raw by the memory and as fields by the tracker
    typedef union packed {
        logic [`POS_BITS:0] raw;            // Flat memory index
        struct packed {
            logic                 bootPage; // Top bit picks the bootloop bank
            logic [`POS_BITS-1:0] position; // Bubble position within the loop
        } fields;
    } storeAddr_u;

    // One position's worth of bubble data
    // Bit 0 leaves in window A, bit 1 in window B
    typedef logic [`DATA_BITS-1:0] bubbleWord_t;

endpackage

`default_nettype wire

// File: hdl/pageStore.sv
`timescale 1ns/10ps
`default_nettype none

`include "bubbleDrive_params.svh"

module pageStore import bubblePkg::*;
(
    input  wire          clock12MHz,

    input  wire          loadEn,      // Host write strobe
    input  storeAddr_u   loadAddr,    // Host write address
    input  bubbleWord_t  loadData,    // Host write word

    input  storeAddr_u   rdAddr,      // Bank and position from the tracker
    input  wire          replicate,   // Replicate window
    output bubbleWord_t  rdData       // Registered read word
);

    // Data bank in the low half, bootloop bank in the high half
    bubbleWord_t  mem [2**(`POS_BITS+1)];

    logic         repPrev;            // replicate one clock back
    logic         rdEn;

    assign rdEn = replicate & ~repPrev;   // First replicate clock only

    always_ff @(posedge clock12MHz)
    begin
        repPrev <= replicate;
    end

    // Host load port
    always_ff @(posedge clock12MHz)
    begin
        if (loadEn)
        begin
            mem[loadAddr.raw] <= loadData;
        end
    end

    // Read lands one clock after the window opens
    always_ff @(posedge clock12MHz)
    begin
        if (rdEn)
        begin
            rdData <= mem[rdAddr.raw];
        end
    end

    // Host writes belong before the run, never across a replicate
    noLoadDuringRep: assert property (@(posedge clock12MHz)
        replicate |-> !loadEn);

endmodule

`default_nettype wire

// File: hdl/positionTracker.sv
`timescale 1ns/10ps
`default_nettype none

`include "bubbleDrive_params.svh"

module positionTracker import bubblePkg::*;
(
    input  wire         clock12MHz,
    input  wire         rstN,

    input  wire         positionChange,   // Two clock pulse from the timing side
    input  wire         pageSelect,       // Bootloop bank select

    output storeAddr_u  rdAddr            // Store read address
);

    logic                 pchgPrev;       // positionChange one clock back
    logic                 pchgRise;
    logic [`POS_BITS-1:0] position;       // Current bubble position

    // Only the first clock of the pair advances
    assign pchgRise = positionChange & ~pchgPrev;

    always_ff @(posedge clock12MHz or negedge rstN)
    begin
        if (!rstN)
        begin
            pchgPrev <= 1'b0;
            position <= '0;
        end
        else
        begin
            pchgPrev <= positionChange;
            if (pchgRise)
            begin
                if (position == `POS_BITS'(`BUBBLE_POSITIONS - 1))
                begin
                    position <= '0;             // Loop revolution complete
                end
                else
                begin
                    position <= position + 1'b1;
                end
            end
        end
    end

    // Bank bit on top with position below
    always_comb
    begin
        rdAddr.fields.bootPage = pageSelect;
        rdAddr.fields.position = position;
    end

endmodule

`default_nettype wire

// File: hdl/timingGenerator.sv
`timescale 1ns/10ps
`default_nettype none

`include "bubbleDrive_params.svh"

module timingGenerator
(
    input  wire  clock12MHz,
    input  wire  rstN,

    input  wire  moduleEn,        // Low holds the drive stopped
    input  wire  shiftEnN,        // Active low shift request
    input  wire  repEnN,          // Active low replicator request
    input  wire  bootEn,          // Bootloop page request

    output logic coilEnN,         // Coil run, active low
    output logic positionChange,  // Two clock pulse per rotation
    output logic positionLatch,   // Replicate while bootloop selected
    output logic pageSelect,      // Synchronized bootEn
    output logic replicate,       // Replicate window
    output logic winA,            // First data output window
    output logic winB             // Second data output window
);

    // Bit order is {shift, replicate, boot}, all active high internally
    logic [2:0]             ctrlRaw;
    logic [2:0]             syncReg [`SYNC_STAGES];
    logic                   shiftActive;
    logic                   repActive;
    logic                   bootActive;

    logic [`CNT_BITS-1:0]   rotCount;     // Field rotation counter
    logic                   inCoil;       // Count inside coil window

    // moduleEn low forces the stopped, replicator-off state
    assign ctrlRaw = {moduleEn & ~shiftEnN,
                      moduleEn & ~repEnN,
                      moduleEn & bootEn};

    always_ff @(posedge clock12MHz or negedge rstN)
    begin
        if (!rstN)
        begin
            syncReg <= '{default: '0};  // Stopped, no replication, data page
        end
        else
        begin
            syncReg[0] <= ctrlRaw;
            for (int i = 1; i < `SYNC_STAGES; i++)
            begin
                syncReg[i] <= syncReg[i-1];
            end
        end
    end

    assign shiftActive = syncReg[`SYNC_STAGES-1][2];
    assign repActive   = syncReg[`SYNC_STAGES-1][1];
    assign bootActive  = syncReg[`SYNC_STAGES-1][0];

    assign inCoil = (rotCount >= `CNT_COIL_ON) && (rotCount <= `CNT_COIL_OFF);

    // Rotation counter
    always_ff @(posedge clock12MHz or negedge rstN)
    begin
        if (!rstN)
        begin
            rotCount <= '0;
        end
        else if (shiftActive)
        begin
            if (rotCount == `CNT_WRAP)
            begin
                rotCount <= `CNT_BITS'(`CNT_LOOP);   // Next rotation
            end
            else
            begin
                rotCount <= rotCount + 1'b1;
            end
        end
        else if (!inCoil)
        begin
            rotCount <= '0;                     // Idle, or past the last stop count
        end
        else if (rotCount == `CNT_XEND)
        begin
            rotCount <= `CNT_BITS'(`CNT_YSTART);  // Skip to the -Y phase
        end
        else
        begin
            // Either side of the jump, run on to the end of the coil window
            rotCount <= rotCount + 1'b1;
        end
    end

    // Strobe decode, straight off the count
    assign coilEnN        = ~inCoil;
    assign positionChange = (rotCount == `CNT_PCHG) || (rotCount == `CNT_PCHG + 1);
    assign replicate      = repActive
                            && (rotCount >= `CNT_REP)
                            && (rotCount <  `CNT_REP + `REP_LEN);
    assign winA           = (rotCount >= `CNT_WINA) && (rotCount < `CNT_WINA + `WIN_LEN);
    assign winB           = (rotCount >= `CNT_WINB) && (rotCount < `CNT_WINB + `WIN_LEN);
    assign positionLatch  = replicate & bootActive;
    assign pageSelect     = bootActive;

    // Stop sequence tops out one past the coil window
    countInRange: assert property (@(posedge clock12MHz) disable iff (!rstN)
        rotCount <= `CNT_COIL_OFF + 1);

    // Bubbles only move with the field running
    pchgNeedsCoil: assert property (@(posedge clock12MHz) disable iff (!rstN)
        positionChange |-> !coilEnN);

endmodule

`default_nettype wire

// File: tb/bubbleDriveTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "bubbleDrive_params.svh"

module bubbleDriveTb import bubblePkg::*;
();

    localparam int MAX_RECORDS  = 32;
    localparam int STORE_WORDS  = 2 * `BUBBLE_POSITIONS;   // Data bank plus bootloop bank
    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES  = 20;

    logic         clock12MHz;
    logic         rstN;
    logic         moduleEn;
    logic         shiftEnN;
    logic         repEnN;
    logic         bootEn;
    logic         loadEn;
    storeAddr_u   loadAddr;
    bubbleWord_t  loadData;
    wire          coilEnN;
    wire          positionChange;
    wire          positionLatch;
    wire          pageSelect;
    wire          dataOut;
    wire          dataValid;

    logic [91:0]  records [MAX_RECORDS];      // Raw lines of the vector file
    bubbleWord_t  storeModel [STORE_WORDS];   // Expected store contents

    int           mismatchErrors;
    int           otherErrors;
    int           cycleCount;
    int           cycleLimit;
    int           pchgCount;                  // Pulses seen this scenario
    int           latchCount;
    int           coilOnCount;                // Clocks with the coil running
    logic         pchgPrev;
    logic         latchPrev;
    logic         validPrev;
    logic         gotBits [$];                // First bit of each output window
    logic [63:0]  expStream;                  // Expected bits in window order
    int           expBitCount;
    int           nextPos;                    // Tracked position at scenario start

    bubbleDrive UUT
    (
        .clock12MHz     (clock12MHz),
        .rstN           (rstN),
        .moduleEn       (moduleEn),
        .shiftEnN       (shiftEnN),
        .repEnN         (repEnN),
        .bootEn         (bootEn),
        .loadEn         (loadEn),
        .loadAddr       (loadAddr),
        .loadData       (loadData),
        .coilEnN        (coilEnN),
        .positionChange (positionChange),
        .positionLatch  (positionLatch),
        .pageSelect     (pageSelect),
        .dataOut        (dataOut),
        .dataValid      (dataValid)
    );

    initial
    begin
        clock12MHz = 1'b0;
        forever #5 clock12MHz = ~clock12MHz;  // 10 ns period
    end

    // Run limit from the scenario lengths
    always @(posedge clock12MHz)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout: run still busy after %0d cycles", cycleLimit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            mismatchErrors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkWord(input string name, input bubbleWord_t got, input bubbleWord_t exp);
        if (got !== exp)
        begin
            mismatchErrors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input int got, input int exp);
        if (got != exp)
        begin
            mismatchErrors++;
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Output monitor sampled mid-cycle
    always @(negedge clock12MHz)
    begin
        if (rstN)
        begin
            if (positionChange && !pchgPrev)
                pchgCount++;
            if (positionLatch && !latchPrev)
                latchCount++;
            if (!coilEnN)
                coilOnCount++;
            if (dataValid && !validPrev)
            begin
                gotBits.push_back(dataOut);     // New window opens
                if (gotBits.size() > expBitCount)
                begin
                    otherErrors++;
                    $display("Error at %0t: dataValid rose where no window was expected", $time);
                end
            end
            if (dataValid && gotBits.size() > 0 && gotBits.size() <= expBitCount)
                checkBit("dataOut", dataOut, expStream[gotBits.size() - 1]);  // Whole window
        end
        pchgPrev  = positionChange;
        latchPrev = positionLatch;
        validPrev = dataValid;
    end

    task automatic runScenario(input logic [91:0] rec);
        logic         modOn;
        logic         repOn;
        logic         bootOn;
        int           rotations;
        int           addr;
        bubbleWord_t  gotWord;
        modOn     = rec[84];
        repOn     = modOn & ~rec[76];
        bootOn    = modOn & rec[72];
        rotations = int'(rec[71:64]);
        @(posedge clock12MHz);
        pchgCount   = 0;
        latchCount  = 0;
        coilOnCount = 0;
        gotBits.delete();
        expStream   = rec[63:0];
        expBitCount = repOn ? 2 * rotations : 0;
        moduleEn <= rec[84];
        shiftEnN <= rec[80];
        repEnN   <= rec[76];
        bootEn   <= rec[72];
        if (rotations == 0)
        begin
            repeat (200) @(posedge clock12MHz);  // Drive must stay stopped
        end
        else
        begin
            while (pchgCount < rotations - 1)
                @(posedge clock12MHz);
            // Release mid-rotation well past the stop jump point
            repeat (59) @(posedge clock12MHz);
            @(negedge clock12MHz);
            checkBit("coilEnN", coilEnN, 1'b0);
            checkBit("pageSelect", pageSelect, bootOn);
            @(posedge clock12MHz);
            shiftEnN <= 1'b1;
            @(negedge clock12MHz);
            while (coilEnN !== 1'b1)
                @(negedge clock12MHz);          // Stop sequence runs out
        end
        repeat (8) @(posedge clock12MHz);
        @(negedge clock12MHz);
        checkBit("coilEnN", coilEnN, 1'b1);
        checkCount("positionChange pulses", pchgCount, rotations);
        checkCount("positionLatch pulses", latchCount, (bootOn && repOn) ? rotations : 0);
        checkCount("output windows", gotBits.size(), expBitCount);
        if (rotations == 0)
            checkCount("coil running clocks", coilOnCount, 0);
        if (repOn && gotBits.size() == expBitCount)
        begin
            for (int k = 0; k < rotations; k++)
            begin
                addr    = (bootOn ? `BUBBLE_POSITIONS : 0) + (nextPos + k) % `BUBBLE_POSITIONS;
                gotWord = {gotBits[2*k+1], gotBits[2*k]};   // Window B bit on top
                checkWord($sformatf("dataOut word of rotation %0d", k), gotWord,
                          storeModel[addr]);
            end
        end
        nextPos = (nextPos + rotations) % `BUBBLE_POSITIONS;
    endtask

    initial
    begin
        int                 storeCount;
        int                 runCount;
        int                 chunk;
        logic [`POS_BITS:0] addrRaw;
        rstN     = 1'b0;
        moduleEn = 1'b0;
        shiftEnN = 1'b1;
        repEnN   = 1'b1;
        bootEn   = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        mismatchErrors = 0;
        otherErrors    = 0;
        cycleCount     = 0;
        pchgCount      = 0;
        latchCount     = 0;
        coilOnCount    = 0;
        pchgPrev       = 1'b0;
        latchPrev      = 1'b0;
        validPrev      = 1'b0;
        expStream      = '0;
        expBitCount    = 0;
        nextPos        = 0;
        storeCount     = 0;
        runCount       = 0;
        for (int i = 0; i < MAX_RECORDS; i++)
            records[i] = '0;
        for (int i = 0; i < STORE_WORDS; i++)
            storeModel[i] = '0;
        $readmemh("tb/bubbleDriveVectors.txt", records);

        // Unpack store chunks and budget cycles per run
        cycleLimit = RESET_CYCLES + STORE_WORDS + 2 + IDLE_CYCLES + 8;
        for (int i = 0; i < MAX_RECORDS; i++)
        begin
            if (records[i][91:88] == 4'h1)
            begin
                chunk = int'(records[i][85:84]);
                for (int w = 0; w < 32; w++)
                    storeModel[chunk*32 + w] = records[i][2*w +: 2];
                storeCount++;
            end
            else if (records[i][91:88] == 4'h2)
            begin
                cycleLimit += 120 * (int'(records[i][71:64]) + 2);
                runCount++;
            end
        end
        if (storeCount != 4 || runCount == 0)
        begin
            otherErrors++;
            $display("Error: vector file gave %0d store lines and %0d runs", storeCount, runCount);
        end

        repeat (RESET_CYCLES) @(posedge clock12MHz);
        rstN <= 1'b1;

        // Host load of both banks while stopped
        addrRaw = '0;
        for (int i = 0; i < STORE_WORDS; i++)
        begin
            @(posedge clock12MHz);
            loadEn       <= 1'b1;
            loadAddr.raw <= addrRaw;
            loadData     <= storeModel[i];
            addrRaw       = addrRaw + 1'b1;
        end
        @(posedge clock12MHz);
        loadEn <= 1'b0;

        // Idle drive after reset
        repeat (IDLE_CYCLES) @(posedge clock12MHz);
        @(negedge clock12MHz);
        checkBit("coilEnN", coilEnN, 1'b1);
        checkCount("positionChange pulses", pchgCount, 0);
        checkCount("coil running clocks", coilOnCount, 0);
        checkCount("output windows", gotBits.size(), 0);

        for (int i = 0; i < MAX_RECORDS; i++)
        begin
            if (records[i][91:88] == 4'h2)
                runScenario(records[i]);
        end

        $display("Errors: %0d mismatches, %0d other", mismatchErrors, otherErrors);
        if (mismatchErrors == 0 && otherErrors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/bubbleDriveVectors.txt
// Each line is 23 hex digits, first digit is the line kind
// Kind 1 store chunk: 1, chunk, 00000, 16 digits of data, word i in bits [2i+1:2i]
// Chunks 0-1 are data page positions 0-63, chunks 2-3 the bootloop page
// Kind 2 run: 2, moduleEn, shiftEnN, repEnN, bootEn, rotations (2 digits), expected stream
// Expected stream holds two bits per replicated rotation, window A bit lowest
1000000FEDCBA9876543210
11000000123456789ABCDEF
12000001B1B1B1B1B1B1B1B
1300000E4E4E4E4E4E4E4E4
// Drive disabled, shift request ignored
20000000000000000000000
// Data page, positions 0-3
21000040000000000000010
// Replicator off, positions 4-6 pass unread
21010030000000000000000
// Data page resumes at position 7
21000060000000000000950
// Bootloop page, positions 13-17
210010500000000000002C6
// Data page, positions 18-37
2100014000000DEFFEDCBA9
// Bootloop page, positions 38-63 then wrap to 0-3
210011E01BE4E4E4E4E4E4E
// Data page after the wrap, positions 4-5
21000020000000000000002

// File: vlog.f
+incdir+hdl
hdl/bubblePkg.sv
hdl/timingGenerator.sv
hdl/positionTracker.sv
hdl/pageStore.sv
hdl/bubbleOutput.sv
hdl/bubbleDrive.sv
tb/bubbleDriveTb.sv
